// File: flist.f
src/ks10Pkg.sv
src/cromDecode.sv
src/trapFlags.sv
src/niDispatch.sv
src/microAddr.sv
src/useqDispatch.sv
tests/useqDispatch_assert.sv
tests/useqDispatch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the microsequencer dispatch testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module useqDispatch_tb \
   -f flist.f \
   -o useqDispatchSim

./obj_dir/useqDispatchSim

// File: tests/useqDispatch_tb.sv
`timescale 1ns/1ps

module useqDispatch_tb
   import ks10Pkg::*;
();

   ////////////////////////////////////////
   // Run length and watchdog budget
   ////////////////////////////////////////

   localparam int resetCycles  = 4;
   localparam int seqCycles    = 12;
   localparam int niCycles     = 64 * 6;
   localparam int trapCycles   = 20;
   localparam int enableCycles = 45;
   localparam int randomCycles = 2000;
   localparam int totalCycles  = resetCycles + seqCycles + niCycles + trapCycles
                                 + enableCycles + randomCycles;
   localparam int timeoutNs    = totalCycles * 8 + 1000;

   // DUT ports
   logic                   clk;
   logic                   rst;
   logic                   clken;
   logic [cromWidth-1:0]   crom;
   logic                   cslTrapEn;
   logic                   cpuRun;
   logic                   memCycle;
   logic [addrWidth-1:0]   cromAddr;
   logic [dispNiWidth-1:0] niOut;
   logic                   trapCycle;

   // Reference state
   logic [addrWidth-1:0] mAddr;
   logic [addrWidth-1:0] mRet;
   logic                 mTrapEn;
   logic                 mTrap1;
   logic                 mTrap2;
   logic                 mTrapCycle;
   string                testName;

   useqDispatch useqDispatch_inst (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .crom      (crom),
      .cslTrapEn (cslTrapEn),
      .cpuRun    (cpuRun),
      .memCycle  (memCycle),
      .cromAddr  (cromAddr),
      .dispNi    (niOut),
      .trapCycle (trapCycle)
   );

   // 8 ns period
   always #4 clk = ~clk;

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // NI code: both, TRAP2, TRAP1, halt, run, memCycle on top
   function automatic logic [3:0] niRef(input logic csl, input logic te, input logic t1,
                                        input logic t2, input logic run, input logic mem);
      logic [2:0] code;
      if (!(csl && te))
         code = niRun;
      else if (t1 && t2)
         code = niBoth;
      else if (t2)
         code = niTrap2;
      else if (t1)
         code = niTrap1;
      else if (!run)
         code = niHalt;
      else
         code = niRun;
      return {mem, code};
   endfunction

   // Spare bits 23..21 left at zero
   function automatic logic [cromWidth-1:0] makeWord(input logic [11:0] jump,
      input logic [2:0] disp, input logic en, input logic [3:0] spec, input logic data);
      return {3'b000, data, spec, en, disp, jump};
   endfunction

   // Special function on a plain jump
   function automatic logic [cromWidth-1:0] specWord(input logic [3:0] spec,
                                                     input logic data);
      return makeWord(12'h0c0, dispJump, 1'b1, spec, data);
   endfunction

   always @(posedge clk or posedge rst)
   begin : refModel
      logic [2:0] dispKind;
      logic [3:0] specKind;
      logic [3:0] niCode;
      if (rst)
      begin
         mAddr      = '0;
         mRet       = '0;
         mTrapEn    = 1'b0;
         mTrap1     = 1'b0;
         mTrap2     = 1'b0;
         mTrapCycle = 1'b0;
      end
      else if (clken)
      begin
         dispKind = crom[dispMsb:dispLsb];
         specKind = crom[specMsb:specLsb];
         // Code from the flags before this edge
         niCode   = niRef(cslTrapEn, mTrapEn, mTrap1, mTrap2, cpuRun, memCycle);
         case (dispKind)
            ks10Pkg::dispNi: mAddr = crom[jMsb:jLsb] | {8'h00, niCode};
            dispCall:
            begin
               mRet  = mAddr + 12'd1;
               mAddr = crom[jMsb:jLsb];
            end
            dispRet: mAddr = mRet;
            default: mAddr = crom[jMsb:jLsb];
         endcase
         if (crom[specEnBit])
         begin
            case (specKind)
               specLoadNiCond: mTrapCycle = cslTrapEn & mTrapEn & (mTrap1 | mTrap2);
               specSetTrap1:   mTrap1 = 1'b1;
               specSetTrap2:   mTrap2 = 1'b1;
               specClrTraps:
               begin
                  mTrap1 = 1'b0;
                  mTrap2 = 1'b0;
               end
               specLoadTrapEn: mTrapEn = crom[trapEnDataBit];
               default:        ;
            endcase
         end
      end
   end

   ////////////////////////////////////////
   // Compare
   ////////////////////////////////////////

   task automatic checkValue(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("FAILED %s %s expected 0x%0h actual 0x%0h", testName, what, expected, actual);
         $display("** FAIL **");
         $fatal(1, "Output mismatch");
      end
   endtask

   // Outputs settled mid-cycle, inputs moved at +1 ns
   always @(negedge clk)
   begin
      if (!rst)
      begin
         checkValue("cromAddr", mAddr, cromAddr);
         checkValue("dispNi", niRef(cslTrapEn, mTrapEn, mTrap1, mTrap2, cpuRun, memCycle),
                    niOut);
         checkValue("trapCycle", mTrapCycle, trapCycle);
      end
   end

   // One microword per edge
   task automatic issue(input logic [cromWidth-1:0] word, input logic en);
      crom  = word;
      clken = en;
      @(posedge clk);
      #1;
   endtask

   initial
   begin
      #(timeoutNs);
      $display("Timeout: the tests did not finish in the expected time");
      $display("** FAIL **");
      $fatal(1, "Watchdog expired");
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial
   begin : stimulus
      int unsigned          seedDummy;
      int                   i;
      logic [5:0]           combo;
      logic [3:0]           expNi;
      logic [addrWidth-1:0] holdAddr;
      logic [3:0]           holdNi;
      logic                 holdCycle;
      logic [cromWidth-1:0] word;
      seedDummy = $urandom(32'hf9a8665f);
      clk       = 1'b0;
      rst       = 1'b1;
      clken     = 1'b0;
      crom      = '0;
      cslTrapEn = 1'b0;
      cpuRun    = 1'b0;
      memCycle  = 1'b0;
      testName  = "reset";
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      checkValue("cromAddr", 12'h000, cromAddr);
      checkValue("trapCycle", 1'b0, trapCycle);
      checkValue("dispNi", {1'b0, niRun}, niOut);
      memCycle = 1'b1;
      #1;
      checkValue("dispNi", {1'b1, niRun}, niOut);
      memCycle = 1'b0;

      // Call saves 124, then FFF wraps to 000
      testName = "sequencing";
      issue(makeWord(12'h123, dispJump, 1'b0, specNone, 1'b0), 1'b1);
      checkValue("jump", 12'h123, cromAddr);
      issue(makeWord(12'h400, dispCall, 1'b0, specNone, 1'b0), 1'b1);
      checkValue("call", 12'h400, cromAddr);
      issue(makeWord(12'h0ab, dispJump, 1'b0, specNone, 1'b0), 1'b1);
      checkValue("jump", 12'h0ab, cromAddr);
      issue(makeWord(12'h777, dispRet, 1'b0, specNone, 1'b0), 1'b1);
      checkValue("return", 12'h124, cromAddr);
      issue(makeWord(12'hfff, dispJump, 1'b0, specNone, 1'b0), 1'b1);
      issue(makeWord(12'h200, dispCall, 1'b0, specNone, 1'b0), 1'b1);
      issue(makeWord(12'h345, dispJump, 1'b0, specNone, 1'b0), 1'b1);
      checkValue("jump", 12'h345, cromAddr);
      issue(makeWord(12'h000, dispRet, 1'b0, specNone, 1'b0), 1'b1);
      checkValue("wrapReturn", 12'h000, cromAddr);

      // Every flag and input combination
      testName = "niPriority";
      for (i = 0; i < 64; i++)
      begin
         combo = i[5:0];
         issue(specWord(specClrTraps, 1'b0), 1'b1);
         issue(specWord(specLoadTrapEn, combo[2]), 1'b1);
         if (combo[0])
            issue(specWord(specSetTrap1, 1'b0), 1'b1);
         if (combo[1])
            issue(specWord(specSetTrap2, 1'b0), 1'b1);
         cslTrapEn = combo[3];
         cpuRun    = combo[4];
         memCycle  = combo[5];
         #1;
         expNi = niRef(combo[3], combo[2], combo[0], combo[1], combo[4], combo[5]);
         checkValue("dispNi", expNi, niOut);
         issue(makeWord(12'h5a0, ks10Pkg::dispNi, 1'b0, specNone, 1'b0), 1'b1);
         checkValue("niJump", 12'h5a0 | {8'h00, expNi}, cromAddr);
      end

      testName  = "trapCycle";
      cslTrapEn = 1'b1;
      cpuRun    = 1'b1;
      issue(specWord(specClrTraps, 1'b0), 1'b1);
      issue(specWord(specLoadTrapEn, 1'b1), 1'b1);
      issue(specWord(specSetTrap1, 1'b0), 1'b1);
      issue(specWord(specNone, 1'b0), 1'b1);
      checkValue("plainWord", 1'b0, trapCycle);
      issue(specWord(specLoadNiCond, 1'b0), 1'b1);
      checkValue("loadTrap1", 1'b1, trapCycle);
      issue(specWord(specClrTraps, 1'b0), 1'b1);
      checkValue("holdOnClear", 1'b1, trapCycle);
      issue(makeWord(12'h010, dispJump, 1'b0, specNone, 1'b0), 1'b1);
      checkValue("holdOnJump", 1'b1, trapCycle);
      issue(specWord(specLoadNiCond, 1'b0), 1'b1);
      checkValue("loadNoTrap", 1'b0, trapCycle);
      issue(specWord(specSetTrap2, 1'b0), 1'b1);
      cslTrapEn = 1'b0;
      issue(specWord(specLoadNiCond, 1'b0), 1'b1);
      checkValue("consoleOff", 1'b0, trapCycle);
      cslTrapEn = 1'b1;
      issue(specWord(specLoadNiCond, 1'b0), 1'b1);
      checkValue("loadTrap2", 1'b1, trapCycle);
      issue(specWord(specLoadTrapEn, 1'b0), 1'b1);
      issue(specWord(specLoadNiCond, 1'b0), 1'b1);
      checkValue("aprOff", 1'b0, trapCycle);

      // TRAP2 pending with trapCycle low, so a stray load would show
      testName = "clockEnable";
      issue(specWord(specLoadTrapEn, 1'b1), 1'b1);
      holdAddr  = cromAddr;
      holdNi    = niOut;
      holdCycle = trapCycle;
      // Directed trap words first, then random words, enable low
      for (i = 0; i < 42; i++)
      begin
         if (i == 0)
            word = specWord(specLoadNiCond, 1'b0);
         else if (i == 1)
            word = specWord(specClrTraps, 1'b0);
         else
            word = $urandom;
         issue(word, 1'b0);
         checkValue("cromAddr", holdAddr, cromAddr);
         checkValue("dispNi", holdNi, niOut);
         checkValue("trapCycle", holdCycle, trapCycle);
      end

      // Enable high about three edges in four
      testName = "randomMix";
      for (i = 0; i < randomCycles; i++)
      begin
         cslTrapEn = $urandom % 2;
         cpuRun    = $urandom % 2;
         memCycle  = $urandom % 2;
         issue($urandom, ($urandom % 4) != 0);
      end

      clken = 1'b0;
      @(negedge clk);
      #1;
      $display("** PASS **");
      $finish;
   end

endmodule

// File: tests/useqDispatch_assert.sv
`timescale 1ns/1ps

module useqDispatch_assert
   import ks10Pkg::*;
(
   input logic                 clk,
   input logic                 rst,
   input logic                 clken,
   input logic                 loadNiCond,
   input logic [addrWidth-1:0] cromAddr,
   input logic                 trapCycle
);

   ////////////////////////////////////////
   // Reset
   ////////////////////////////////////////

   // Address sits at zero while reset is held
   resetAddr: assert property (@(posedge clk) rst |-> cromAddr == '0)
      else $error("cromAddr is not zero during reset");

   // First edge out of reset still starts from zero
   releaseAddr: assert property (@(posedge clk) $fell(rst) |-> cromAddr == '0)
      else $error("cromAddr is not zero after reset");

   ////////////////////////////////////////
   // Clock enable and trap cycle
   ////////////////////////////////////////

   // Disabled edge changes nothing
   holdState: assert property (@(posedge clk) disable iff (rst)
      !clken |=> ($stable(cromAddr) && $stable(trapCycle)))
      else $error("State changed on an edge with clken low");

   // Trap cycle only loads on an enabled LOADNICOND word
   trapCycleLoad: assert property (@(posedge clk) disable iff (rst)
      !(clken && loadNiCond) |=> $stable(trapCycle))
      else $error("trapCycle changed without an enabled loadNiCond");

endmodule

bind useqDispatch useqDispatch_assert useqDispatch_assert_inst (
   .clk        (clk),
   .rst        (rst),
   .clken      (clken),
   .loadNiCond (loadNiCond),
   .cromAddr   (cromAddr),
   .trapCycle  (trapCycle)
);

// File: src/useqDispatch.sv
`timescale 1ns/1ps

module useqDispatch
   import ks10Pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clken,
   input  logic [cromWidth-1:0]   crom,
   input  logic                   cslTrapEn,
   input  logic                   cpuRun,
   input  logic                   memCycle,
   output logic [addrWidth-1:0]   cromAddr,
   output logic [dispNiWidth-1:0] dispNi,
   output logic                   trapCycle
);

   ////////////////////////////////////////
   // Internal wires
   ////////////////////////////////////////

   // Decoded microword
   logic [addrWidth-1:0] jumpAddr;
   dispSelT              dispSel;

   // Special strobes
   logic loadNiCond;
   logic setTrap1;
   logic setTrap2;
   logic clrTraps;
   logic loadTrapEn;
   logic trapEnData;

   // Trap state
   logic trapEn;
   logic trap1;
   logic trap2;

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   cromDecode cromDecode_inst (
      .crom       (crom),
      .jumpAddr   (jumpAddr),
      .dispSel    (dispSel),
      .loadNiCond (loadNiCond),
      .setTrap1   (setTrap1),
      .setTrap2   (setTrap2),
      .clrTraps   (clrTraps),
      .loadTrapEn (loadTrapEn),
      .trapEnData (trapEnData)
   );

   ////////////////////////////////////////
   // Trap state and NI dispatch
   ////////////////////////////////////////

   trapFlags trapFlags_inst (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .setTrap1   (setTrap1),
      .setTrap2   (setTrap2),
      .clrTraps   (clrTraps),
      .loadTrapEn (loadTrapEn),
      .trapEnData (trapEnData),
      .trapEn     (trapEn),
      .trap1      (trap1),
      .trap2      (trap2)
   );

   niDispatch niDispatch_inst (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .loadNiCond (loadNiCond),
      .cslTrapEn  (cslTrapEn),
      .trapEn     (trapEn),
      .trap1      (trap1),
      .trap2      (trap2),
      .cpuRun     (cpuRun),
      .memCycle   (memCycle),
      .dispNi     (dispNi),
      .trapCycle  (trapCycle)
   );

   ////////////////////////////////////////
   // Microaddress
   ////////////////////////////////////////

   microAddr microAddr_inst (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .jumpAddr (jumpAddr),
      .dispSel  (dispSel),
      .dispNi   (dispNi),
      .cromAddr (cromAddr)
   );

endmodule

// File: src/microAddr.sv
`timescale 1ns/1ps

module microAddr
   import ks10Pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clken,
   input  logic [addrWidth-1:0]   jumpAddr,
   input  dispSelT                dispSel,
   input  logic [dispNiWidth-1:0] dispNi,
   output logic [addrWidth-1:0]   cromAddr
);

   ////////////////////////////////////////
   // Next address
   ////////////////////////////////////////

   // One-level return stack
   logic [addrWidth-1:0] retAddr;
   // Address after the call, wraps at the top
   logic [addrWidth-1:0] incAddr;
   logic [addrWidth-1:0] nextAddr;
   // NI code widened to the address
   logic [addrWidth-1:0] niMask;

   assign incAddr = cromAddr + 1'b1;
   assign niMask  = {{(addrWidth-dispNiWidth){1'b0}}, dispNi};

   // Enum literal named explicitly, the port shares its name
   always_comb
   begin
      case (dispSel)
         ks10Pkg::dispNi: nextAddr = jumpAddr | niMask;
         dispCall:        nextAddr = jumpAddr;
         dispRet:         nextAddr = retAddr;
         default:         nextAddr = jumpAddr;
      endcase
   end

   ////////////////////////////////////////
   // Address and return registers
   ////////////////////////////////////////

   // Microaddress
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cromAddr <= '0;
      end
      else if (clken)
      begin
         cromAddr <= nextAddr;
      end
   end

   // Return address
   // Saved only on a call
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         retAddr <= '0;
      end
      else if (clken && (dispSel == dispCall))
      begin
         retAddr <= incAddr;
      end
   end

endmodule

// File: src/niDispatch.sv
`timescale 1ns/1ps

module niDispatch
   import ks10Pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clken,
   input  logic                   loadNiCond,
   input  logic                   cslTrapEn,
   input  logic                   trapEn,
   input  logic                   trap1,
   input  logic                   trap2,
   input  logic                   cpuRun,
   input  logic                   memCycle,
   output logic [dispNiWidth-1:0] dispNi,
   output logic                   trapCycle
);

   ////////////////////////////////////////
   // Trap qualification
   ////////////////////////////////////////

   // Console and APR must both allow traps
   logic   trapsOn;
   // Any pending trap that is allowed
   logic   trapPending;
   niCodeT niCode;

   assign trapsOn     = cslTrapEn & trapEn;
   assign trapPending = trapsOn & (trap1 | trap2);

   ////////////////////////////////////////
   // NI dispatch code
   ////////////////////////////////////////

   // Priority: both, TRAP2, TRAP1, halt, run
   always_comb
   begin
      if (!trapsOn)
         niCode = niRun;
      else if (trap1 && trap2)
         niCode = niBoth;
      else if (trap2)
         niCode = niTrap2;
      else if (trap1)
         niCode = niTrap1;
      else if (!cpuRun)
         niCode = niHalt;
      else
         niCode = niRun;
   end

   // Memory cycle rides in the top bit
   assign dispNi = {memCycle, niCode};

   ////////////////////////////////////////
   // Trap cycle flag
   ////////////////////////////////////////

   // Sampled only on a LOADNICOND word, held otherwise
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trapCycle <= 1'b0;
      end
      else if (clken && loadNiCond)
      begin
         trapCycle <= trapPending;
      end
   end

endmodule

// File: src/trapFlags.sv
`timescale 1ns/1ps

module trapFlags
(
   input  logic clk,
   input  logic rst,
   input  logic clken,
   input  logic setTrap1,
   input  logic setTrap2,
   input  logic clrTraps,
   input  logic loadTrapEn,
   input  logic trapEnData,
   output logic trapEn,
   output logic trap1,
   output logic trap2
);

   ////////////////////////////////////////
   // APR trap enable
   ////////////////////////////////////////

   // Loaded from the microword data bit
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trapEn <= 1'b0;
      end
      else if (clken && loadTrapEn)
      begin
         trapEn <= trapEnData;
      end
   end

   ////////////////////////////////////////
   // PC trap flags
   ////////////////////////////////////////

   // TRAP1
   // Set and clear never arrive together
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trap1 <= 1'b0;
      end
      else if (clken)
      begin
         if (clrTraps)
            trap1 <= 1'b0;
         else if (setTrap1)
            trap1 <= 1'b1;
      end
   end

   // TRAP2
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trap2 <= 1'b0;
      end
      else if (clken)
      begin
         if (clrTraps)
            trap2 <= 1'b0;
         else if (setTrap2)
            trap2 <= 1'b1;
      end
   end

endmodule

// File: src/cromDecode.sv
`timescale 1ns/1ps

module cromDecode
   import ks10Pkg::*;
(
   input  logic [cromWidth-1:0] crom,
   output logic [addrWidth-1:0] jumpAddr,
   output dispSelT              dispSel,
   output logic                 loadNiCond,
   output logic                 setTrap1,
   output logic                 setTrap2,
   output logic                 clrTraps,
   output logic                 loadTrapEn,
   output logic                 trapEnData
);

   ////////////////////////////////////////
   // Raw fields
   ////////////////////////////////////////

   logic [dispMsb-dispLsb:0] dispRaw;
   logic [specMsb-specLsb:0] specRaw;
   logic                     specEn;

   assign dispRaw = crom[dispMsb:dispLsb];
   assign specRaw = crom[specMsb:specLsb];
   assign specEn  = crom[specEnBit];

   // Jump address goes straight through
   assign jumpAddr = crom[jMsb:jLsb];

   // Value for the trap enable load
   assign trapEnData = crom[trapEnDataBit];

   ////////////////////////////////////////
   // Dispatch select
   ////////////////////////////////////////

   // Unused codes fold onto a plain jump
   always_comb
   begin
      case (dispRaw)
         dispNi:   dispSel = dispNi;
         dispCall: dispSel = dispCall;
         dispRet:  dispSel = dispRet;
         default:  dispSel = dispJump;
      endcase
   end

   ////////////////////////////////////////
   // Special strobes
   ////////////////////////////////////////

   // One-hot, nothing unless the enable bit is set
   always_comb
   begin
      loadNiCond = 1'b0;
      setTrap1   = 1'b0;
      setTrap2   = 1'b0;
      clrTraps   = 1'b0;
      loadTrapEn = 1'b0;
      if (specEn)
      begin
         case (specRaw)
            specLoadNiCond: loadNiCond = 1'b1;
            specSetTrap1:   setTrap1   = 1'b1;
            specSetTrap2:   setTrap2   = 1'b1;
            specClrTraps:   clrTraps   = 1'b1;
            specLoadTrapEn: loadTrapEn = 1'b1;
            // specNone and spare codes
            default:        ;
         endcase
      end
   end

endmodule

// File: src/ks10Pkg.sv
package ks10Pkg;

   ////////////////////////////////////////
   // Microword and address widths
   ////////////////////////////////////////

   // Control ROM word
   localparam int cromWidth = 24;
   // Microaddress
   localparam int addrWidth = 12;
   // NI dispatch code, memCycle on top
   localparam int dispNiWidth = 4;

   ////////////////////////////////////////
   // Microword field layout
   ////////////////////////////////////////

   // Jump address
   localparam int jLsb = 0;
   localparam int jMsb = 11;

   // Dispatch select
   localparam int dispLsb = 12;
   localparam int dispMsb = 14;

   // Special function enable and select
   localparam int specEnBit = 15;
   localparam int specLsb = 16;
   localparam int specMsb = 19;

   // Data for the APR trap enable, bits 23..21 spare
   localparam int trapEnDataBit = 20;

   ////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////

   // Dispatch kinds, codes 4..7 behave as a plain jump
   typedef enum logic [2:0] {
      dispJump = 3'd0,
      dispNi   = 3'd1,
      dispCall = 3'd2,
      dispRet  = 3'd3
   } dispSelT;

   // Special functions, codes 6..15 are no-ops
   typedef enum logic [3:0] {
      specNone       = 4'd0,
      specLoadNiCond = 4'd1,
      specSetTrap1   = 4'd2,
      specSetTrap2   = 4'd3,
      specClrTraps   = 4'd4,
      specLoadTrapEn = 4'd5
   } specSelT;

   // Low three bits of the NI dispatch
   typedef enum logic [2:0] {
      niBoth  = 3'd1,
      niTrap2 = 3'd2,
      niTrap1 = 3'd3,
      niHalt  = 3'd5,
      niRun   = 3'd7
   } niCodeT;

endpackage
